//--- Bender.yml
package:
  name: pcie_tx

sources:
  - pcie_tx_link_pkg.sv
  - pcie_tx_arb_pkg.sv
  - pcie_tx_ifs.sv
  - tx_arbiter.sv
  - tx_beat_select.sv
  - tx_output_stage.sv
  - tx_stats.sv
  - pcie_tx.sv
  - target: test
    files:
      - tb_pcie_tx.sv

//--- pcie_tx.f
pcie_tx_link_pkg.sv
pcie_tx_arb_pkg.sv
pcie_tx_ifs.sv
tx_arbiter.sv
tx_beat_select.sv
tx_output_stage.sv
tx_stats.sv
pcie_tx.sv
tb_pcie_tx.sv

//--- pcie_tx.sv
// PCIe transmit top level
// arbitrates three requesters onto the link through a three stage pipe
`timescale 1ns/100ps

module pcie_tx (
   input  logic                                    pcie_clk,
   input  logic                                    rst_reg,
   // write source
   input  logic                                    wr_req,
   output logic                                    wr_ack,
   input  logic                                    wr_beat_valid,
   input  logic [pcie_tx_link_pkg::data_w-1:0]     wr_data,
   input  logic [pcie_tx_link_pkg::rem_w-1:0]      wr_rem,
   input  logic                                    wr_sof,
   input  logic                                    wr_eof,
   input  pcie_tx_link_pkg::merge_e                wr_merge,
   input  logic [pcie_tx_link_pkg::mem_addr_w-1:0] wr_mem_addr_hi,
   input  logic [pcie_tx_link_pkg::mem_addr_w-1:0] wr_mem_addr_lo,
   input  logic                                    wr_mem_en_hi,
   input  logic                                    wr_mem_en_lo,
   // read source
   input  logic                                    rd_req,
   output logic                                    rd_ack,
   input  logic                                    rd_beat_valid,
   input  logic [pcie_tx_link_pkg::data_w-1:0]     rd_data,
   input  logic [pcie_tx_link_pkg::rem_w-1:0]      rd_rem,
   input  logic                                    rd_sof,
   input  logic                                    rd_eof,
   // completion source
   input  logic                                    cm_req,
   output logic                                    cm_ack,
   input  logic                                    cm_beat_valid,
   input  logic [pcie_tx_link_pkg::data_w-1:0]     cm_data,
   input  logic [pcie_tx_link_pkg::rem_w-1:0]      cm_rem,
   input  logic                                    cm_sof,
   input  logic                                    cm_eof,
   input  pcie_tx_link_pkg::merge_e                cm_merge,
   input  logic [pcie_tx_link_pkg::mem_addr_w-1:0] cm_mem_addr_hi,
   input  logic [pcie_tx_link_pkg::mem_addr_w-1:0] cm_mem_addr_lo,
   input  logic                                    cm_mem_en_hi,
   input  logic                                    cm_mem_en_lo,
   // memory reads
   output logic [pcie_tx_link_pkg::mem_addr_w-1:0] mem_addr_hi,
   output logic [pcie_tx_link_pkg::mem_addr_w-1:0] mem_addr_lo,
   output logic                                    mem_en_hi,
   output logic                                    mem_en_lo,
   input  logic [pcie_tx_link_pkg::word_w-1:0]     mem_data_hi,
   input  logic [pcie_tx_link_pkg::word_w-1:0]     mem_data_lo,
   // link
   output logic [pcie_tx_link_pkg::data_w-1:0]     tx_data,
   output logic [pcie_tx_link_pkg::rem_w-1:0]      tx_rem,
   output logic                                    tx_sof,
   output logic                                    tx_eof,
   output logic                                    tx_valid,
   input  logic                                    tx_ready,
   input  logic [pcie_tx_arb_pkg::num_src-1:0]     tx_buf_av,
   input  logic                                    bus_master_en,
   output logic                                    tx_stall,
   // statistics
   output logic [31:0]                             stat_word_cnt,
   output logic [31:0]                             stat_wr_cnt,
   output logic [31:0]                             stat_rd_cnt,
   output logic [31:0]                             stat_cm_cnt
);
   import pcie_tx_link_pkg::*;
   import pcie_tx_arb_pkg::*;

   tx_source_if if_wr ();
   tx_source_if if_rd ();
   tx_source_if if_cm ();
   tx_beat_if   s1_beat ();

   logic [num_src-1:0] done;
   logic               beat_accept;

   // ----------------------------------------
   // source ports into interfaces
   // ----------------------------------------
   assign {if_wr.req, if_wr.beat_valid, if_wr.sof, if_wr.eof} =
          {wr_req, wr_beat_valid, wr_sof, wr_eof};
   assign {if_wr.data, if_wr.rem} = {wr_data, wr_rem};
   assign if_wr.merge = wr_merge;
   assign {if_wr.mem_addr_hi, if_wr.mem_addr_lo, if_wr.mem_en_hi, if_wr.mem_en_lo} =
          {wr_mem_addr_hi, wr_mem_addr_lo, wr_mem_en_hi, wr_mem_en_lo};
   assign wr_ack = if_wr.ack;

   // read beats carry no memory data
   assign {if_rd.req, if_rd.beat_valid, if_rd.sof, if_rd.eof} =
          {rd_req, rd_beat_valid, rd_sof, rd_eof};
   assign {if_rd.data, if_rd.rem} = {rd_data, rd_rem};
   assign if_rd.merge = merge_none;
   assign {if_rd.mem_addr_hi, if_rd.mem_addr_lo, if_rd.mem_en_hi, if_rd.mem_en_lo} = '0;
   assign rd_ack = if_rd.ack;

   assign {if_cm.req, if_cm.beat_valid, if_cm.sof, if_cm.eof} =
          {cm_req, cm_beat_valid, cm_sof, cm_eof};
   assign {if_cm.data, if_cm.rem} = {cm_data, cm_rem};
   assign if_cm.merge = cm_merge;
   assign {if_cm.mem_addr_hi, if_cm.mem_addr_lo, if_cm.mem_en_hi, if_cm.mem_en_lo} =
          {cm_mem_addr_hi, cm_mem_addr_lo, cm_mem_en_hi, cm_mem_en_lo};
   assign cm_ack = if_cm.ack;

   assign beat_accept = tx_valid & tx_ready;

   tx_arbiter u_arbiter (
      .pcie_clk, .rst_reg, .tx_buf_av, .bus_master_en,
      .src_wr (if_wr), .src_rd (if_rd), .src_cm (if_cm),
      .done
   );

   tx_beat_select u_beat_select (
      .pcie_clk, .rst_reg, .stall (tx_stall),
      .src_wr (if_wr), .src_rd (if_rd), .src_cm (if_cm),
      .mem_addr_hi, .mem_addr_lo, .mem_en_hi, .mem_en_lo,
      .beat (s1_beat)
   );

   tx_output_stage u_output_stage (
      .pcie_clk, .rst_reg, .beat (s1_beat),
      .mem_data_hi, .mem_data_lo,
      .tx_data, .tx_rem, .tx_sof, .tx_eof, .tx_valid, .tx_ready,
      .stall (tx_stall)
   );

   tx_stats u_stats (
      .pcie_clk, .rst_reg, .beat_accept, .done,
      .stat_word_cnt, .stat_wr_cnt, .stat_rd_cnt, .stat_cm_cnt
   );

endmodule

//--- pcie_tx_arb_pkg.sv
// PCIe transmit arbiter definitions
// requester classes, arbiter states and the guard gap between grants

package pcie_tx_arb_pkg;

   localparam int num_src      = 3;
   localparam int guard_cycles = 2;

   // requester class, the value is also its tx_buf_av bit
   typedef enum logic [1:0] {
      src_rd = 2'd0,
      src_wr = 2'd1,
      src_cm = 2'd2
   } src_e;

   typedef enum logic [1:0] {
      arb_idle,
      arb_busy,
      arb_guard1,
      arb_guard2
   } arb_state_e;

endpackage

//--- pcie_tx_ifs.sv
// PCIe transmit interfaces
// requester side of one source class, and the stage 1 beat bus
`timescale 1ns/100ps

interface tx_source_if;
   import pcie_tx_link_pkg::*;

   logic                  req;
   logic                  ack;
   logic                  beat_valid;
   logic [data_w-1:0]     data;
   logic [rem_w-1:0]      rem;
   logic                  sof;
   logic                  eof;
   merge_e                merge;
   // memory read issued alongside the beat
   logic [mem_addr_w-1:0] mem_addr_hi;
   logic [mem_addr_w-1:0] mem_addr_lo;
   logic                  mem_en_hi;
   logic                  mem_en_lo;

   modport arbiter (input req, output ack);

   modport monitor (
      input ack, beat_valid, data, rem, sof, eof, merge,
      input mem_addr_hi, mem_addr_lo, mem_en_hi, mem_en_lo
   );
endinterface

interface tx_beat_if;
   import pcie_tx_link_pkg::*;

   logic              valid;
   logic [data_w-1:0] data;
   logic [rem_w-1:0]  rem;
   logic              sof;
   logic              eof;
   merge_e            merge;

   modport source (output valid, data, rem, sof, eof, merge);
   modport sink   (input valid, data, rem, sof, eof, merge);
endinterface

//--- pcie_tx_link_pkg.sv
// PCIe transmit link definitions
// beat and memory word widths, memory merge modes, word byte swap

package pcie_tx_link_pkg;

   // link beat and its byte enables
   localparam int data_w     = 64;
   localparam int rem_w      = 8;

   // memory read side
   localparam int word_w     = 32;
   localparam int mem_addr_w = 12;

   // where the returned memory words land in a beat
   typedef enum logic [2:0] {
      merge_none   = 3'd0,
      merge_lo_low = 3'd1,
      merge_hi_low = 3'd2,
      merge_hi_lo  = 3'd3,
      merge_lo_hi  = 3'd4
   } merge_e;

   // memory holds words little endian, the link sends them big endian
   function automatic logic [word_w-1:0] byte_swap(input logic [word_w-1:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

endpackage

//--- tb_pcie_tx.sv
// PCIe transmit testbench
// table-driven source and memory models around pcie_tx with a scoreboard
// for link beats, grant order, credit gating and statistics
`timescale 1ns/100ps

module tb_pcie_tx;
   import pcie_tx_link_pkg::*;
   import pcie_tx_arb_pkg::*;

   typedef struct packed {
      int              ph;
      src_e            c;
      int              n;
      logic [63:0]     start;
      merge_e          m;
      logic [11:0]     base;
   } pkt_t;

   localparam int num_pkts = 17;
   localparam int limit    = 2000;

   // phase 0 all sources from reset, 1 merge modes with random ready,
   // 2 write credit withheld, 3 bus mastering off
   pkt_t pkts [num_pkts] = '{
      '{0, src_wr, 3, 64'h1111_0000_0000_0000, merge_none,   12'h000},
      '{0, src_rd, 2, 64'h2222_0000_0000_0000, merge_none,   12'h000},
      '{0, src_cm, 4, 64'h3333_0000_0000_0000, merge_none,   12'h000},
      '{0, src_wr, 2, 64'h1111_0000_0000_0100, merge_none,   12'h000},
      '{0, src_rd, 3, 64'h2222_0000_0000_0100, merge_none,   12'h000},
      '{0, src_cm, 1, 64'h3333_0000_0000_0100, merge_none,   12'h000},
      '{1, src_wr, 3, 64'hA0A0_B1B1_C2C2_0000, merge_lo_low, 12'h100},
      '{1, src_cm, 2, 64'hD3D3_E4E4_F5F5_0000, merge_hi_low, 12'h200},
      '{1, src_wr, 4, 64'h0123_4567_89AB_0000, merge_hi_lo,  12'h300},
      '{1, src_cm, 3, 64'hFEDC_BA98_7654_0000, merge_lo_hi,  12'hFFC},
      '{1, src_rd, 5, 64'h5555_6666_7777_0000, merge_none,   12'h000},
      '{1, src_wr, 2, 64'h9999_8888_7777_0000, merge_lo_hi,  12'h040},
      '{1, src_cm, 2, 64'h4444_3333_2222_0000, merge_hi_lo,  12'h080},
      '{2, src_wr, 2, 64'hC0DE_0000_0000_0000, merge_hi_lo,  12'h400},
      '{3, src_cm, 3, 64'hBEEF_0000_0000_0000, merge_hi_low, 12'h600},
      '{3, src_wr, 2, 64'h7A7A_0000_0000_0000, merge_lo_low, 12'h700},
      '{3, src_rd, 2, 64'h6B6B_0000_0000_0000, merge_none,   12'h000}
   };

   logic                  pcie_clk;
   logic                  rst_reg;
   logic                  wr_req, wr_beat_valid, wr_sof, wr_eof;
   logic                  rd_req, rd_beat_valid, rd_sof, rd_eof;
   logic                  cm_req, cm_beat_valid, cm_sof, cm_eof;
   logic                  wr_ack, rd_ack, cm_ack;
   logic [data_w-1:0]     wr_data, rd_data, cm_data;
   logic [rem_w-1:0]      wr_rem, rd_rem, cm_rem;
   merge_e                wr_merge, cm_merge;
   logic [mem_addr_w-1:0] wr_mem_addr_hi, wr_mem_addr_lo, cm_mem_addr_hi, cm_mem_addr_lo;
   logic                  wr_mem_en_hi, wr_mem_en_lo, cm_mem_en_hi, cm_mem_en_lo;
   logic [mem_addr_w-1:0] mem_addr_hi, mem_addr_lo;
   logic                  mem_en_hi, mem_en_lo;
   logic [word_w-1:0]     mem_data_hi, mem_data_lo;
   logic [data_w-1:0]     tx_data;
   logic [rem_w-1:0]      tx_rem;
   logic                  tx_sof, tx_eof, tx_valid, tx_ready, tx_stall;
   logic [num_src-1:0]    tx_buf_av;
   logic                  bus_master_en;
   logic [31:0]           stat_word_cnt, stat_wr_cnt, stat_rd_cnt, stat_cm_cnt;

   integer                seed = 99008;
   int                    errors = 0;
   int                    delivered = 0;
   logic                  rand_ready = 1'b0;
   logic                  no_wr_ack = 1'b0;
   logic                  no_rd_ack = 1'b0;
   logic                  cm_gated_grant = 1'b0;
   // {sof, eof, rem, data} in grant order
   logic [73:0]           exp_q [$];
   src_e                  grant_log [$];

   pcie_tx u_pcie_tx (.*);

   always #4 pcie_clk = ~pcie_clk;

   task automatic check_value(input string name, input logic [73:0] exp, input logic [73:0] act);
      if (exp !== act) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("timeout while waiting for %s", what);
      $display("Test failures found");
      $finish;
   endtask

   function automatic logic ack_of(input src_e c);
      case (c)
         src_wr:  return wr_ack;
         src_cm:  return cm_ack;
         default: return rd_ack;
      endcase
   endfunction

   // beat i of a packet as the link should carry it
   function automatic logic [73:0] expected_beat(input int idx, input int i);
      logic [63:0] d;
      logic [31:0] w_hi;
      logic [31:0] w_lo;
      d    = pkts[idx].start + i;
      w_hi = byte_swap({20'h0, pkts[idx].base + 12'(2 * i + 1)} + 32'h1000_0000);
      w_lo = byte_swap({20'h0, pkts[idx].base + 12'(2 * i)} ^ 32'h0000_5A5A);
      case (pkts[idx].m)
         merge_lo_low: d[31:0] = w_lo;
         merge_hi_low: d[31:0] = w_hi;
         merge_hi_lo:  d = {w_hi, w_lo};
         merge_lo_hi:  d = {w_lo, w_hi};
         default:      d = d;
      endcase
      return {i == 0, i == pkts[idx].n - 1, (i == pkts[idx].n - 1) ? 8'hF0 : 8'hFF, d};
   endfunction

   task automatic drive_req(input src_e c, input logic v);
      case (c)
         src_wr:  wr_req <= v;
         src_cm:  cm_req <= v;
         default: rd_req <= v;
      endcase
   endtask

   // source side beat, memory addresses follow the beat index
   task automatic drive_beat(input src_e c, input logic v, input int idx, input int i);
      logic [73:0] b;
      logic [11:0] a_hi;
      logic [11:0] a_lo;
      logic        e_hi;
      logic        e_lo;
      merge_e      m;
      m    = pkts[idx].m;
      b    = {i == 0, i == pkts[idx].n - 1, (i == pkts[idx].n - 1) ? 8'hF0 : 8'hFF,
              pkts[idx].start + 64'(i)};
      a_hi = pkts[idx].base + 12'(2 * i + 1);
      a_lo = pkts[idx].base + 12'(2 * i);
      e_hi = m inside {merge_hi_low, merge_hi_lo, merge_lo_hi};
      e_lo = m inside {merge_lo_low, merge_hi_lo, merge_lo_hi};
      case (c)
         src_wr: begin
            {wr_sof, wr_eof, wr_rem, wr_data} <= b;
            wr_beat_valid <= v;
            wr_merge      <= m;
            {wr_mem_addr_hi, wr_mem_addr_lo} <= {a_hi, a_lo};
            {wr_mem_en_hi, wr_mem_en_lo}     <= {e_hi, e_lo};
         end
         src_cm: begin
            {cm_sof, cm_eof, cm_rem, cm_data} <= b;
            cm_beat_valid <= v;
            cm_merge      <= m;
            {cm_mem_addr_hi, cm_mem_addr_lo} <= {a_hi, a_lo};
            {cm_mem_en_hi, cm_mem_en_lo}     <= {e_hi, e_lo};
         end
         default: begin
            {rd_sof, rd_eof, rd_rem, rd_data} <= b;
            rd_beat_valid <= v;
         end
      endcase
   endtask

   // four-phase request, beats only where the stall register stays low
   task automatic send_packet(input int idx);
      src_e c;
      int   cnt;
      int   i;
      logic pres;
      c    = pkts[idx].c;
      cnt  = 0;
      i    = 0;
      pres = 1'b0;
      @(posedge pcie_clk);
      while (ack_of(c)) begin
         if (++cnt > limit) timeout_abort("ack to fall before a new request");
         @(posedge pcie_clk);
      end
      drive_req(c, 1'b1);
      cnt = 0;
      @(posedge pcie_clk);
      while (!ack_of(c)) begin
         if (++cnt > limit) timeout_abort("ack after request");
         @(posedge pcie_clk);
      end
      grant_log.push_back(c);
      for (int k = 0; k < pkts[idx].n; k++) exp_q.push_back(expected_beat(idx, k));
      cnt = 0;
      forever begin
         if (pres && !tx_stall) i++;
         if (i == pkts[idx].n) begin
            drive_beat(c, 1'b0, idx, i - 1);
            drive_req(c, 1'b0);
            break;
         end
         // stall after this edge is the hold seen now
         pres = !(tx_valid && !tx_ready);
         drive_beat(c, pres, idx, i);
         if (++cnt > limit) timeout_abort("beats of a packet to be taken");
         @(posedge pcie_clk);
      end
   endtask

   task automatic run_class(input src_e c, input int ph);
      for (int k = 0; k < num_pkts; k++) begin
         if (pkts[k].ph == ph && pkts[k].c == c) send_packet(k);
      end
   endtask

   // withheld credit or mastering, then released after a watch window
   task automatic gate_window(input int ph);
      if (ph >= 2) begin
         repeat (2) @(posedge pcie_clk);
         no_wr_ack <= 1'b1;
         no_rd_ack <= (ph == 3);
         repeat (80) @(posedge pcie_clk);
         no_wr_ack     <= 1'b0;
         no_rd_ack     <= 1'b0;
         tx_buf_av     <= 3'b111;
         bus_master_en <= 1'b1;
      end
   endtask

   // registered memory read
   always @(posedge pcie_clk) begin
      if (mem_en_hi) mem_data_hi <= {20'h0, mem_addr_hi} + 32'h1000_0000;
      if (mem_en_lo) mem_data_lo <= {20'h0, mem_addr_lo} ^ 32'h0000_5A5A;
   end

   always @(posedge pcie_clk) begin
      tx_ready <= rand_ready ? (($random(seed) % 4) != 0) : 1'b1;
   end

   // ----------------------------------------
   // scoreboard and gating monitors
   // ----------------------------------------
   always @(posedge pcie_clk) begin
      if (!rst_reg && tx_valid && tx_ready) begin
         delivered++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("link delivered a beat that no source sent: %h", tx_data);
         end else begin
            check_value("link beat", exp_q.pop_front(), {tx_sof, tx_eof, tx_rem, tx_data});
         end
      end
      if (no_wr_ack && wr_ack) begin
         errors++;
         $display("write source was granted while gated");
      end
      if (no_rd_ack && rd_ack) begin
         errors++;
         $display("read source was granted with bus mastering off");
      end
      // completions keep their grant without bus mastering
      if (no_rd_ack && cm_ack) begin
         cm_gated_grant <= 1'b1;
      end
   end

   initial begin
      int   cnt;
      int   n_wr;
      int   n_rd;
      int   n_cm;
      int   n_beats;
      src_e order [6];
      order    = '{src_wr, src_cm, src_rd, src_wr, src_cm, src_rd};
      pcie_clk = 1'b0;
      rst_reg  = 1'b1;
      {wr_req, wr_beat_valid, wr_sof, wr_eof, wr_data, wr_rem} = '0;
      {rd_req, rd_beat_valid, rd_sof, rd_eof, rd_data, rd_rem} = '0;
      {cm_req, cm_beat_valid, cm_sof, cm_eof, cm_data, cm_rem} = '0;
      wr_merge = merge_none;
      cm_merge = merge_none;
      {wr_mem_addr_hi, wr_mem_addr_lo, wr_mem_en_hi, wr_mem_en_lo} = '0;
      {cm_mem_addr_hi, cm_mem_addr_lo, cm_mem_en_hi, cm_mem_en_lo} = '0;
      mem_data_hi   = '0;
      mem_data_lo   = '0;
      tx_ready      = 1'b1;
      tx_buf_av     = 3'b111;
      bus_master_en = 1'b1;
      repeat (16) @(posedge pcie_clk);

      // idle state held by reset
      check_value("acks after reset", 0, {wr_ack, rd_ack, cm_ack});
      check_value("tx_valid after reset", 0, tx_valid);
      check_value("memory enables after reset", 0, {mem_en_hi, mem_en_lo});
      check_value("stats after reset", 0,
                  stat_word_cnt | stat_wr_cnt | stat_rd_cnt | stat_cm_cnt);
      rst_reg <= 1'b0;

      for (int ph = 0; ph < 4; ph++) begin
         @(posedge pcie_clk);
         rand_ready <= (ph != 0);
         if (ph == 2) tx_buf_av <= 3'b101;
         if (ph == 3) bus_master_en <= 1'b0;
         fork
            run_class(src_wr, ph);
            run_class(src_rd, ph);
            run_class(src_cm, ph);
            gate_window(ph);
         join
         if (ph == 0) begin
            for (int k = 0; k < 6; k++) begin
               check_value($sformatf("grant %0d", k), order[k], grant_log[k]);
            end
         end
      end

      cnt = 0;
      while (exp_q.size() != 0) begin
         if (++cnt > limit) timeout_abort("link to drain the expected beats");
         @(posedge pcie_clk);
      end
      for (int k = 0; k < 4; k++) @(posedge pcie_clk);

      n_wr    = 0;
      n_rd    = 0;
      n_cm    = 0;
      n_beats = 0;
      foreach (pkts[k]) begin
         n_beats += pkts[k].n;
         if (pkts[k].c == src_wr) n_wr++;
         if (pkts[k].c == src_rd) n_rd++;
         if (pkts[k].c == src_cm) n_cm++;
      end
      check_value("completion grant with bus mastering off", 1, cm_gated_grant);
      check_value("delivered beats", n_beats, delivered);
      check_value("stat_word_cnt", n_beats, stat_word_cnt);
      check_value("stat_wr_cnt", n_wr, stat_wr_cnt);
      check_value("stat_rd_cnt", n_rd, stat_rd_cnt);
      check_value("stat_cm_cnt", n_cm, stat_cm_cnt);

      $display("errors %0d, beats delivered %0d", errors, delivered);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- tx_arbiter.sv
// transmit arbiter
// round-robin grant of the link among write, read and completion sources,
// gated by link buffer credit and bus mastering
`timescale 1ns/100ps

module tx_arbiter (
   input  logic                                pcie_clk,
   input  logic                                rst_reg,
   input  logic [pcie_tx_arb_pkg::num_src-1:0] tx_buf_av,
   input  logic                                bus_master_en,
   tx_source_if.arbiter                        src_wr,
   tx_source_if.arbiter                        src_rd,
   tx_source_if.arbiter                        src_cm,
   output logic [pcie_tx_arb_pkg::num_src-1:0] done
);
   import pcie_tx_arb_pkg::*;

   arb_state_e         state;
   src_e               ptr;
   src_e               pick;
   logic               found;
   logic [num_src-1:0] req_vec;
   logic [num_src-1:0] elig;
   logic [num_src-1:0] ack_vec;
   logic               ack_any;

   // rotation wr, cm, rd
   function automatic src_e next_src(input src_e s);
      case (s)
         pcie_tx_arb_pkg::src_wr: return pcie_tx_arb_pkg::src_cm;
         pcie_tx_arb_pkg::src_cm: return pcie_tx_arb_pkg::src_rd;
         default:                 return pcie_tx_arb_pkg::src_wr;
      endcase
   endfunction

   assign req_vec[pcie_tx_arb_pkg::src_wr] = src_wr.req;
   assign req_vec[pcie_tx_arb_pkg::src_rd] = src_rd.req;
   assign req_vec[pcie_tx_arb_pkg::src_cm] = src_cm.req;

   assign src_wr.ack = ack_vec[pcie_tx_arb_pkg::src_wr];
   assign src_rd.ack = ack_vec[pcie_tx_arb_pkg::src_rd];
   assign src_cm.ack = ack_vec[pcie_tx_arb_pkg::src_cm];
   assign ack_any    = |ack_vec;

   // completions only need credit
   always_comb begin
      elig = req_vec & tx_buf_av;
      if (!bus_master_en) begin
         elig[pcie_tx_arb_pkg::src_wr] = 1'b0;
         elig[pcie_tx_arb_pkg::src_rd] = 1'b0;
      end
   end

   // first eligible class from the pointer on
   always_comb begin
      src_e cand;
      cand  = ptr;
      pick  = ptr;
      found = 1'b0;
      for (int i = 0; i < num_src; i++) begin
         if (!found && elig[cand]) begin
            pick  = cand;
            found = 1'b1;
         end
         cand = next_src(cand);
      end
   end

   // ----------------------------------------
   // grant FSM
   // ----------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (rst_reg) begin
         state   <= arb_idle;
         ptr     <= pcie_tx_arb_pkg::src_wr;
         ack_vec <= '0;
         done    <= '0;
      end else begin
         done <= '0;
         case (state)
            arb_idle: begin
               if (found) begin
                  ack_vec[pick] <= 1'b1;
                  ptr           <= next_src(pick);
                  state         <= arb_busy;
               end
            end
            arb_busy: begin
               // granted source has dropped req after its last beat
               if (!(|(req_vec & ack_vec))) begin
                  done    <= ack_vec;
                  ack_vec <= '0;
                  state   <= arb_guard1;
               end
            end
            arb_guard1: state <= arb_guard2;
            default:    state <= arb_idle;
         endcase
      end
   end

   a_one_ack: assert property (@(posedge pcie_clk) disable iff (rst_reg)
      $onehot0(ack_vec));

   // release only from busy, then no grant for the guard gap
   a_ack_release: assert property (@(posedge pcie_clk) disable iff (rst_reg)
      $fell(ack_any) |-> ($past(state == arb_busy) && !ack_any) ##1 !ack_any [*guard_cycles]);

endmodule

//--- tx_beat_select.sv
// transmit pipeline stage 1
// registers the granted source's beat and issues its memory read
`timescale 1ns/100ps

module tx_beat_select (
   input  logic                                    pcie_clk,
   input  logic                                    rst_reg,
   input  logic                                    stall,
   tx_source_if.monitor                            src_wr,
   tx_source_if.monitor                            src_rd,
   tx_source_if.monitor                            src_cm,
   output logic [pcie_tx_link_pkg::mem_addr_w-1:0] mem_addr_hi,
   output logic [pcie_tx_link_pkg::mem_addr_w-1:0] mem_addr_lo,
   output logic                                    mem_en_hi,
   output logic                                    mem_en_lo,
   tx_beat_if.source                               beat
);
   import pcie_tx_link_pkg::*;

   logic                  sel_valid;
   logic [data_w-1:0]     sel_data;
   logic [rem_w-1:0]      sel_rem;
   logic                  sel_sof;
   logic                  sel_eof;
   merge_e                sel_merge;
   logic [mem_addr_w-1:0] sel_addr_hi;
   logic [mem_addr_w-1:0] sel_addr_lo;
   logic                  sel_en_hi;
   logic                  sel_en_lo;

   // read source is the default payload, no memory read for it
   always_comb begin
      sel_valid   = 1'b0;
      sel_data    = src_rd.data;
      sel_rem     = src_rd.rem;
      sel_sof     = src_rd.sof;
      sel_eof     = src_rd.eof;
      sel_merge   = merge_none;
      sel_addr_hi = mem_addr_hi;
      sel_addr_lo = mem_addr_lo;
      sel_en_hi   = 1'b0;
      sel_en_lo   = 1'b0;
      if (src_wr.ack) begin
         sel_valid   = src_wr.beat_valid;
         sel_data    = src_wr.data;
         sel_rem     = src_wr.rem;
         sel_sof     = src_wr.sof;
         sel_eof     = src_wr.eof;
         sel_merge   = src_wr.merge;
         sel_addr_hi = src_wr.mem_addr_hi;
         sel_addr_lo = src_wr.mem_addr_lo;
         sel_en_hi   = src_wr.beat_valid & src_wr.mem_en_hi;
         sel_en_lo   = src_wr.beat_valid & src_wr.mem_en_lo;
      end else if (src_cm.ack) begin
         sel_valid   = src_cm.beat_valid;
         sel_data    = src_cm.data;
         sel_rem     = src_cm.rem;
         sel_sof     = src_cm.sof;
         sel_eof     = src_cm.eof;
         sel_merge   = src_cm.merge;
         sel_addr_hi = src_cm.mem_addr_hi;
         sel_addr_lo = src_cm.mem_addr_lo;
         sel_en_hi   = src_cm.beat_valid & src_cm.mem_en_hi;
         sel_en_lo   = src_cm.beat_valid & src_cm.mem_en_lo;
      end else if (src_rd.ack) begin
         sel_valid   = src_rd.beat_valid;
         sel_merge   = src_rd.merge;
      end
   end

   // beat and memory read move together, both frozen by stall
   always_ff @(posedge pcie_clk) begin
      if (!stall) begin
         beat.valid  <= sel_valid;
         beat.data   <= sel_data;
         beat.rem    <= sel_rem;
         beat.sof    <= sel_sof;
         beat.eof    <= sel_eof;
         beat.merge  <= sel_merge;
         mem_addr_hi <= sel_addr_hi;
         mem_addr_lo <= sel_addr_lo;
         mem_en_hi   <= sel_en_hi;
         mem_en_lo   <= sel_en_lo;
      end
      if (rst_reg) begin
         beat.valid <= 1'b0;
         mem_en_hi  <= 1'b0;
         mem_en_lo  <= 1'b0;
      end
   end

   // a beat outside its grant or during stall would be dropped here
   a_beat_granted: assert property (@(posedge pcie_clk) disable iff (rst_reg)
      (src_wr.beat_valid -> src_wr.ack && !stall) &&
      (src_rd.beat_valid -> src_rd.ack && !stall) &&
      (src_cm.beat_valid -> src_cm.ack && !stall));

endmodule

//--- tx_output_stage.sv
// transmit pipeline stages 2 and 3
// merges byte-swapped memory words into the beat and drives the link,
// holding data under back-pressure with skid registers
`timescale 1ns/100ps

module tx_output_stage (
   input  logic                                pcie_clk,
   input  logic                                rst_reg,
   tx_beat_if.sink                             beat,
   input  logic [pcie_tx_link_pkg::word_w-1:0] mem_data_hi,
   input  logic [pcie_tx_link_pkg::word_w-1:0] mem_data_lo,
   output logic [pcie_tx_link_pkg::data_w-1:0] tx_data,
   output logic [pcie_tx_link_pkg::rem_w-1:0]  tx_rem,
   output logic                                tx_sof,
   output logic                                tx_eof,
   output logic                                tx_valid,
   input  logic                                tx_ready,
   output logic                                stall
);
   import pcie_tx_link_pkg::*;

   // stage 2
   logic              s2_valid;
   logic [data_w-1:0] s2_data;
   logic [rem_w-1:0]  s2_rem;
   logic              s2_sof;
   logic              s2_eof;
   merge_e            s2_merge;

   // skid copy of the beat in flight when the link stops
   logic              sk_valid;
   logic [data_w-1:0] sk_data;
   logic [rem_w-1:0]  sk_rem;
   logic              sk_sof;
   logic              sk_eof;
   logic [word_w-1:0] sk_mem_hi;
   logic [word_w-1:0] sk_mem_lo;

   logic              hold;
   logic              stall_d2;
   logic [word_w-1:0] swap_hi;
   logic [word_w-1:0] swap_lo;
   logic [data_w-1:0] merged;

   assign hold = tx_valid & ~tx_ready;

   always_ff @(posedge pcie_clk) begin
      if (rst_reg) begin
         stall    <= 1'b0;
         stall_d2 <= 1'b0;
      end else begin
         stall    <= hold;
         stall_d2 <= stall;
      end
   end

   // ----------------------------------------
   // stage 2, beat meets its memory words
   // ----------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (!stall) begin
         s2_valid <= beat.valid;
         s2_data  <= beat.data;
         s2_rem   <= beat.rem;
         s2_sof   <= beat.sof;
         s2_eof   <= beat.eof;
         s2_merge <= beat.merge;
      end
      // words of the frozen beat, memory moves on to the next address
      if (stall && !stall_d2) begin
         sk_mem_hi <= mem_data_hi;
         sk_mem_lo <= mem_data_lo;
      end
      if (rst_reg) begin
         s2_valid <= 1'b0;
      end
   end

   always_comb begin
      swap_hi = byte_swap(stall_d2 ? sk_mem_hi : mem_data_hi);
      swap_lo = byte_swap(stall_d2 ? sk_mem_lo : mem_data_lo);
      merged  = s2_data;
      case (s2_merge)
         merge_lo_low: merged[word_w-1:0] = swap_lo;
         merge_hi_low: merged[word_w-1:0] = swap_hi;
         merge_hi_lo:  merged = {swap_hi, swap_lo};
         merge_lo_hi:  merged = {swap_lo, swap_hi};
         default:      merged = s2_data;
      endcase
   end

   // ----------------------------------------
   // stage 3, link output and skid
   // ----------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (!hold && stall) begin
         // link ready again, skid goes out first
         tx_valid <= sk_valid;
         tx_data  <= sk_data;
         tx_rem   <= sk_rem;
         tx_sof   <= sk_sof;
         tx_eof   <= sk_eof;
      end else if (!hold) begin
         tx_valid <= s2_valid;
         tx_data  <= merged;
         tx_rem   <= s2_rem;
         tx_sof   <= s2_sof;
         tx_eof   <= s2_eof;
      end else if (!stall) begin
         // first held cycle, pipe still advances once
         sk_valid <= s2_valid;
         sk_data  <= merged;
         sk_rem   <= s2_rem;
         sk_sof   <= s2_sof;
         sk_eof   <= s2_eof;
      end
      if (rst_reg) begin
         tx_valid <= 1'b0;
         sk_valid <= 1'b0;
      end
   end

   a_hold_stable: assert property (@(posedge pcie_clk) disable iff (rst_reg)
      hold |=> tx_valid && $stable(tx_data) && $stable(tx_eof));

endmodule

//--- tx_stats.sv
// transmit statistics
// delivered link beats and finished requests per class
`timescale 1ns/100ps

module tx_stats (
   input  logic                                pcie_clk,
   input  logic                                rst_reg,
   input  logic                                beat_accept,
   input  logic [pcie_tx_arb_pkg::num_src-1:0] done,
   output logic [31:0]                         stat_word_cnt,
   output logic [31:0]                         stat_wr_cnt,
   output logic [31:0]                         stat_rd_cnt,
   output logic [31:0]                         stat_cm_cnt
);
   import pcie_tx_arb_pkg::*;

   always_ff @(posedge pcie_clk) begin
      if (rst_reg) begin
         stat_word_cnt <= '0;
         stat_wr_cnt   <= '0;
         stat_rd_cnt   <= '0;
         stat_cm_cnt   <= '0;
      end else begin
         if (beat_accept)  stat_word_cnt <= stat_word_cnt + 32'd1;
         if (done[src_wr]) stat_wr_cnt   <= stat_wr_cnt + 32'd1;
         if (done[src_rd]) stat_rd_cnt   <= stat_rd_cnt + 32'd1;
         if (done[src_cm]) stat_cm_cnt   <= stat_cm_cnt + 32'd1;
      end
   end

endmodule
